//--- src/mb_pkg.sv
package mb_pkg;

////////////////////////////////////////
// widths and types

	localparam int N_SS     = 10;        // chip selects on the board
	localparam int SPI_W    = 16;        // bits per spi command
	localparam int N_SLICES = 4;         // output slices per pixel word

	typedef logic [SPI_W-1:0] spi_word_t;    // one spi command
	typedef logic [3:0]       ss_index_t;    // select index, 0 to 9
	typedef logic [N_SS-1:0]  ss_vec_t;      // select bus as seen on the pins
	typedef logic [7:0]       adc_byte_t;    // one adc sample
	typedef logic [23:0]      pixel_word_t;  // adc1 on top, adc3 at the bottom
	typedef logic [5:0]       pixel_slice_t; // slices leave highest first

	typedef enum logic [1:0] {
		SPI_IDLE,                            // waiting for trigger
		SPI_SHIFT,                           // select active, bits going out
		SPI_GAP                              // select released, spacing
	} spi_state_t;

	typedef enum logic [1:0] {
		PROG_LAUNCH,                         // first entry after reset
		PROG_WAIT,                           // transfer in flight
		PROG_DONE                            // table written
	} prog_state_t;

////////////////////////////////////////
// peripheral selects and command table

	// temp sensors on 5 and 6 want a high select, all others low
	localparam ss_vec_t SS_ACTIVE_HIGH = 10'b00_0110_0000;

	localparam int N_CMDS = 8;           // table entries

	typedef struct packed {
		ss_index_t target;               // which select
		spi_word_t command;              // word sent to it
	} cmd_entry_t;

	localparam cmd_entry_t CMD_TABLE [N_CMDS] = '{
		'{target: 4'd0, command: 16'h0F21}, // pll divider setup
		'{target: 4'd1, command: 16'h1180}, // pot1 wiper
		'{target: 4'd2, command: 16'h1140}, // pot2 wiper
		'{target: 4'd5, command: 16'h0C60}, // temp sensor, daughter board
		'{target: 4'd6, command: 16'h0C61}, // temp sensor, mother board
		'{target: 4'd7, command: 16'h8401}, // adc1 output format
		'{target: 4'd8, command: 16'h8402}, // adc2 output format
		'{target: 4'd9, command: 16'h8403}  // adc3 output format
	};

endpackage

//--- src/spi_cmd_if.sv
`timescale 1ns/100ps

// one command handed from the sequencer to the spi master
interface spi_cmd_if import mb_pkg::*; ();

	spi_word_t command;  // word to shift out, msb first
	ss_index_t target;   // peripheral index
	logic      trigger;  // single cycle start
	logic      done;     // single cycle, after the select gap

	modport programmer (
		output command,
		output target,
		output trigger,
		input  done
	);

	modport master (
		input  command,
		input  target,
		input  trigger,
		output done
	);

endinterface

//--- src/spi_master.sv
`timescale 1ns/100ps

module spi_master import mb_pkg::*; #(
	parameter int CLK_RATIO = 16,            // clocks per sclk period, even
	parameter int SS_SPACE  = 10             // idle clocks after select release
) (
	input  logic      user_clock,
	input  logic      rst_n,
	spi_cmd_if.master cmd,
	output logic      spi_mosi,
	output logic      spi_sclk,
	output ss_vec_t   spi_ss
);

	localparam int DIV_W = $clog2(CLK_RATIO);
	localparam int BIT_W = $clog2(SPI_W);
	localparam int GAP_W = $clog2(SS_SPACE + 1);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLK_RATIO - 1);
	localparam logic [DIV_W-1:0] DIV_HALF = DIV_W'(CLK_RATIO / 2); // sclk rises here
	localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(SPI_W - 1);
	localparam logic [GAP_W-1:0] GAP_LAST = GAP_W'(SS_SPACE - 1);

	spi_state_t       state;
	logic [DIV_W-1:0] div_cnt;               // position inside one sclk period
	logic [BIT_W-1:0] bit_cnt;               // bits already sent
	logic [GAP_W-1:0] gap_cnt;               // clocks since select release
	spi_word_t        shift_reg;             // msb is on the wire
	ss_index_t        sel;                   // latched target
	ss_vec_t          sel_onehot;            // high = selected, before polarity
	logic             period_end;

	assign period_end = (div_cnt == DIV_LAST);

////////////////////////////////////////
// control fsm

	always_ff @(posedge user_clock)
	begin
		if (!rst_n)
		begin
			state    <= SPI_IDLE;
			div_cnt  <= '0;
			bit_cnt  <= '0;
			gap_cnt  <= '0;
			cmd.done <= 1'b0;
		end
		else
		begin
			cmd.done <= 1'b0;                // pulse only
			case (state)
				SPI_IDLE:
				begin
					div_cnt <= '0;
					bit_cnt <= '0;
					if (cmd.trigger)
						state <= SPI_SHIFT;  // select goes active next cycle
				end
				SPI_SHIFT:
				begin
					div_cnt <= div_cnt + 1'b1;
					if (period_end)
					begin
						div_cnt <= '0;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == BIT_LAST)
						begin
							state   <= SPI_GAP; // release at end of 16th period
							gap_cnt <= '0;
						end
					end
				end
				SPI_GAP:
				begin
					gap_cnt <= gap_cnt + 1'b1;
					if (gap_cnt == GAP_LAST)
					begin
						state    <= SPI_IDLE;
						cmd.done <= 1'b1;    // sequencer may go again
					end
				end
				default: state <= SPI_IDLE;
			endcase
		end
	end

	// command and target held for the whole transfer
	always_ff @(posedge user_clock)
	begin
		if (state == SPI_IDLE && cmd.trigger)
		begin
			shift_reg <= cmd.command;
			sel       <= cmd.target;
		end
		else if (state == SPI_SHIFT && period_end)
			shift_reg <= {shift_reg[SPI_W-2:0], 1'b0}; // next bit while sclk goes low
	end

////////////////////////////////////////
// pins

	assign spi_sclk   = (state == SPI_SHIFT) && (div_cnt >= DIV_HALF); // low half first
	assign spi_mosi   = (state == SPI_SHIFT) && shift_reg[SPI_W-1];
	assign sel_onehot = (state == SPI_SHIFT) ? (ss_vec_t'(1) << sel) : '0;
	assign spi_ss     = sel_onehot ^ ~SS_ACTIVE_HIGH; // per peripheral polarity

	// exactly one peripheral while shifting, none otherwise
	a_one_select: assert property (@(posedge user_clock) disable iff (!rst_n)
		$onehot(spi_ss ^ ~SS_ACTIVE_HIGH) == (state == SPI_SHIFT));

	// mode 0, data may only move during the low half
	a_mosi_stable: assert property (@(posedge user_clock) disable iff (!rst_n)
		spi_sclk |=> (!spi_sclk || $stable(spi_mosi)));

endmodule

//--- src/spi_programmer.sv
`timescale 1ns/100ps

module spi_programmer import mb_pkg::*; (
	input  logic          user_clock,
	input  logic          rst_n,
	spi_cmd_if.programmer cmd,
	output logic          config_done
);

	localparam int ENTRY_W = $clog2(N_CMDS);
	localparam logic [ENTRY_W-1:0] LAST_ENTRY = ENTRY_W'(N_CMDS - 1);

	prog_state_t        state;
	logic [ENTRY_W-1:0] entry;               // table row in flight

	// word and select follow the row, steady while the trigger is up
	assign cmd.command = CMD_TABLE[entry].command;
	assign cmd.target  = CMD_TABLE[entry].target;

	always_ff @(posedge user_clock)
	begin
		if (!rst_n)
		begin
			state       <= PROG_LAUNCH;
			entry       <= '0;
			cmd.trigger <= 1'b0;
			config_done <= 1'b0;
		end
		else
		begin
			cmd.trigger <= 1'b0;             // single cycle
			case (state)
				PROG_LAUNCH:
				begin
					cmd.trigger <= 1'b1;     // row 0, right out of reset
					state       <= PROG_WAIT;
				end
				PROG_WAIT:
				begin
					if (cmd.done)
					begin
						if (entry == LAST_ENTRY)
						begin
							state       <= PROG_DONE;
							config_done <= 1'b1; // stays up until reset
						end
						else
						begin
							entry       <= entry + 1'b1;
							cmd.trigger <= 1'b1; // next row straight after done
						end
					end
				end
				default: config_done <= 1'b1; // parked
			endcase
		end
	end

	// a launched transfer must finish before another is launched
	a_no_retrigger: assert property (@(posedge user_clock) disable iff (!rst_n)
		cmd.trigger |=> (!cmd.trigger throughout (cmd.done [->1])));

endmodule

//--- src/pixel_fifo.sv
`timescale 1ns/100ps

module pixel_fifo import mb_pkg::*; #(
	parameter int FIFO_DEPTH      = 64,      // words, power of two
	parameter int FIFO_READ_RATIO = 4        // clocks per output slice
) (
	input  logic         user_clock,
	input  logic         rst_n,
	input  adc_byte_t    adc_data1,
	input  adc_byte_t    adc_data2,
	input  adc_byte_t    adc_data3,
	input  logic         sample_valid,
	output pixel_slice_t dout,
	output logic         fifo_dout_valid,
	output logic         fifo_overflow
);

	localparam int ADDR_W  = $clog2(FIFO_DEPTH);
	localparam int PTR_W   = ADDR_W + 1;     // extra wrap bit tells full from empty
	localparam int PACE_W  = (FIFO_READ_RATIO > 1) ? $clog2(FIFO_READ_RATIO) : 1;
	localparam int SLC_W   = $clog2(N_SLICES);
	localparam int SLICE_W = $bits(pixel_slice_t);
	localparam logic [PACE_W-1:0] PACE_LAST  = PACE_W'(FIFO_READ_RATIO - 1);
	localparam logic [SLC_W-1:0]  SLICE_LAST = SLC_W'(N_SLICES - 1);

	pixel_word_t       cap_word;             // packed sample
	logic              cap_valid;            // write on this cycle
	pixel_word_t       mem [FIFO_DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic              full;
	logic              empty;
	logic [PACE_W-1:0] pace_cnt;             // free running slice pacing
	logic              pace_tick;
	logic [SLC_W-1:0]  slice_cnt;            // next slice of the head word
	pixel_word_t       head_word;
	logic              send;

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
	               (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

////////////////////////////////////////
// write side

	always_ff @(posedge user_clock)
	begin
		if (sample_valid)
			cap_word <= {adc_data1, adc_data2, adc_data3}; // adc1 on top
		if (cap_valid && !full)
			mem[wr_ptr[ADDR_W-1:0]] <= cap_word;
	end

	always_ff @(posedge user_clock)
	begin
		if (!rst_n)
		begin
			cap_valid     <= 1'b0;
			wr_ptr        <= '0;
			fifo_overflow <= 1'b0;
		end
		else
		begin
			cap_valid <= sample_valid;
			if (cap_valid)
			begin
				if (full)
					fifo_overflow <= 1'b1;   // word dropped, sticky
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

////////////////////////////////////////
// read side

	assign pace_tick = (pace_cnt == PACE_LAST);
	assign head_word = mem[rd_ptr[ADDR_W-1:0]];
	assign send      = pace_tick && !empty;  // head word stays until its last slice

	always_ff @(posedge user_clock)
	begin
		if (!rst_n)
		begin
			pace_cnt        <= '0;
			slice_cnt       <= '0;
			rd_ptr          <= '0;
			fifo_dout_valid <= 1'b0;
		end
		else
		begin
			pace_cnt        <= pace_tick ? '0 : pace_cnt + 1'b1;
			fifo_dout_valid <= send;
			if (send)
			begin
				slice_cnt <= slice_cnt + 1'b1;
				if (slice_cnt == SLICE_LAST)
				begin
					slice_cnt <= '0;
					rd_ptr    <= rd_ptr + 1'b1; // word gone after fourth slice
				end
			end
		end
	end

	always_ff @(posedge user_clock)
	begin
		if (send)
			dout <= head_word[SLICE_W*(N_SLICES-1-slice_cnt) +: SLICE_W]; // highest first
	end

	// occupancy never above depth, so reads never overtake writes
	a_no_underrun: assert property (@(posedge user_clock) disable iff (!rst_n)
		PTR_W'(wr_ptr - rd_ptr) <= PTR_W'(FIFO_DEPTH));

endmodule

//--- src/aclk_generator.sv
`timescale 1ns/100ps

module aclk_generator #(
	parameter int ACLK_RATIO = 32            // clocks per readout period, even
) (
	input  logic user_clock,
	input  logic rst_n,
	output logic adc_read_aclk
);

	localparam int HALF  = ACLK_RATIO / 2;   // clocks per level
	localparam int CNT_W = (HALF > 1) ? $clog2(HALF) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(HALF - 1);

	logic [CNT_W-1:0] level_cnt;             // clocks spent at the current level

	always_ff @(posedge user_clock)
	begin
		if (!rst_n)
		begin
			level_cnt     <= '0;
			adc_read_aclk <= 1'b0;           // starts low, first rise after HALF
		end
		else if (level_cnt == CNT_LAST)
		begin
			level_cnt     <= '0;
			adc_read_aclk <= ~adc_read_aclk;
		end
		else
			level_cnt <= level_cnt + 1'b1;
	end

endmodule

//--- src/mb_top.sv
`timescale 1ns/100ps

module mb_top import mb_pkg::*; #(
	parameter int CLK_RATIO       = 16,      // spi sclk divider
	parameter int SS_SPACE        = 10,      // clocks between spi transfers
	parameter int FIFO_DEPTH      = 64,      // pixel words buffered
	parameter int FIFO_READ_RATIO = 4,       // clocks per output slice
	parameter int ACLK_RATIO      = 32       // readout clock divider
) (
	input  logic         user_clock,
	input  logic         rst_n,
	output logic         spi_mosi,
	output ss_vec_t      spi_ss,
	output logic         spi_sclk,
	output logic         config_done,
	input  adc_byte_t    adc_data1,
	input  adc_byte_t    adc_data2,
	input  adc_byte_t    adc_data3,
	input  logic         sample_valid,
	output pixel_slice_t dout,
	output logic         fifo_dout_valid,
	output logic         fifo_overflow,
	output logic         adc_read_aclk
);

	spi_cmd_if spi_cmd (); // sequencer to master

	spi_programmer programmer_inst (
		.user_clock  (user_clock),
		.rst_n       (rst_n),
		.cmd         (spi_cmd.programmer),
		.config_done (config_done)
	);

	spi_master #(.CLK_RATIO(CLK_RATIO), .SS_SPACE(SS_SPACE)) spi_master_inst (
		.user_clock (user_clock),
		.rst_n      (rst_n),
		.cmd        (spi_cmd.master),
		.spi_mosi   (spi_mosi),
		.spi_sclk   (spi_sclk),
		.spi_ss     (spi_ss)
	);

	pixel_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .FIFO_READ_RATIO(FIFO_READ_RATIO)) pixel_fifo_inst (
		.user_clock      (user_clock),
		.rst_n           (rst_n),
		.adc_data1       (adc_data1),
		.adc_data2       (adc_data2),
		.adc_data3       (adc_data3),
		.sample_valid    (sample_valid),
		.dout            (dout),
		.fifo_dout_valid (fifo_dout_valid),
		.fifo_overflow   (fifo_overflow)
	);

	aclk_generator #(.ACLK_RATIO(ACLK_RATIO)) aclk_gen_inst (
		.user_clock    (user_clock),
		.rst_n         (rst_n),
		.adc_read_aclk (adc_read_aclk)
	);

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
	parameter int HALF_PERIOD  = 20,         // ns per clock level
	parameter int RESET_CYCLES = 10          // rising edges held in reset
) (
	output logic user_clock,
	output logic rst_n
);

	initial
	begin
		user_clock = 1'b0;
		forever #(HALF_PERIOD) user_clock = ~user_clock;
	end

	initial
	begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge user_clock);
		@(negedge user_clock);
		rst_n = 1'b1;                        // released on the falling edge
	end

endmodule

//--- bench/mb_tb.sv
`timescale 1ns/100ps

module mb_tb import mb_pkg::*; ();

	localparam int CLK_RATIO  = 16;          // clocks per sclk period
	localparam int SS_SPACE   = 10;
	localparam int FIFO_DEPTH = 64;
	localparam int READ_RATIO = 4;           // clocks per output slice
	localparam int ACLK_RATIO = 32;

	logic         user_clock;
	logic         rst_n;
	logic         spi_mosi;
	ss_vec_t      spi_ss;
	logic         spi_sclk;
	logic         config_done;
	adc_byte_t    adc_data1;
	adc_byte_t    adc_data2;
	adc_byte_t    adc_data3;
	logic         sample_valid;
	pixel_slice_t dout;
	logic         fifo_dout_valid;
	logic         fifo_overflow;
	logic         adc_read_aclk;

	logic [15:0]  lfsr_state = 16'd64970;
	int unsigned  cycle      = 0;            // rising edges so far
	pixel_word_t  exp_words[$];              // pixel phase, oldest first
	pixel_word_t  ovf_written[$];            // overflow phase in write order
	pixel_word_t  out_word;                  // slices collected so far
	logic         ovf_mode   = 1'b0;
	int           ovf_out    = 0;            // words back in overflow phase
	int           ovf_match  = 0;            // write index of the last word back
	int           slice_k    = 0;
	int           xfer_idx   = 0;            // spi transfers finished
	int           bit_count  = 0;
	spi_word_t    rx_word;                   // peripheral shift register
	logic         ss_was_on  = 1'b0;
	logic         sclk_prev  = 1'b0;
	logic         aclk_prev  = 1'b0;
	int unsigned  last_rise  = 0;            // cycle of the last sclk rise
	int unsigned  aclk_rise  = 0;
	int           aclk_rises = 0;

	tb_clock #(.HALF_PERIOD(20), .RESET_CYCLES(10)) clock_inst (.user_clock, .rst_n);

	mb_top #(.CLK_RATIO(CLK_RATIO), .SS_SPACE(SS_SPACE), .FIFO_DEPTH(FIFO_DEPTH),
		.FIFO_READ_RATIO(READ_RATIO), .ACLK_RATIO(ACLK_RATIO)) mb_top_inst (.*);

	always @(posedge user_clock)
		cycle <= cycle + 1;

////////////////////////////////////////
// reference model and helpers

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
			abort_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state); // one step per bit
			value      = {value[30:0], lfsr_state[0]};
		end
	endtask

	function automatic ss_vec_t expected_select(input ss_index_t idx);
		ss_vec_t v;
		for (int i = 0; i < N_SS; i++)
			v[i] = (i == int'(idx)) ? SS_ACTIVE_HIGH[i] : ~SS_ACTIVE_HIGH[i];
		return v;
	endfunction

	function automatic logic select_active(input ss_vec_t ss);
		return (ss ^ ~SS_ACTIVE_HIGH) != '0;  // any pin away from its idle level
	endfunction

	function automatic pixel_slice_t slice_of(input pixel_word_t w, input int k);
		return w[23 - 6 * k -: 6];            // slice 0 is the top one
	endfunction

	task automatic drive_sample(input pixel_word_t w);
		adc_data1    = w[23:16];
		adc_data2    = w[15:8];
		adc_data3    = w[7:0];
		sample_valid = 1'b1;
	endtask

	// later words may skip dropped ones but never go back
	task automatic match_overflow_word(input pixel_word_t w);
		int k;
		if (ovf_out < FIFO_DEPTH)
		begin
			compare_value("dout word", 32'(w), 32'(ovf_written[ovf_out]));
			ovf_match = ovf_out;
		end
		else
		begin
			k = ovf_match + 1;
			while (k < ovf_written.size() && ovf_written[k] != w)
				k++;
			if (k >= ovf_written.size())
				abort_run($sformatf("output word 0x%06h matches no later written word", w));
			ovf_match = k;
		end
		ovf_out++;
	endtask

////////////////////////////////////////
// monitors on the falling edge

	// spi peripheral model
	always @(negedge user_clock)
	begin
		if (rst_n)
		begin
			if (config_done && xfer_idx != N_CMDS)
				abort_run("config_done rose before the last spi transfer ended");
			if (select_active(spi_ss))
			begin
				if (!ss_was_on)
				begin
					if (xfer_idx >= N_CMDS)
						abort_run("a select went active after the command table ended");
					bit_count = 0;
					last_rise = cycle;       // first rise half a period in
				end
				compare_value("spi_ss", 32'(spi_ss),
					32'(expected_select(CMD_TABLE[xfer_idx].target)));
				if (spi_sclk && !sclk_prev)
				begin
					compare_value("spi_sclk rise spacing", cycle - last_rise,
						(bit_count == 0) ? CLK_RATIO / 2 : CLK_RATIO);
					rx_word   = {rx_word[SPI_W-2:0], spi_mosi}; // msb first
					bit_count = bit_count + 1;
					last_rise = cycle;
				end
			end
			else
			begin
				compare_value("spi_sclk", 32'(spi_sclk), 32'(0)); // parked low
				if (ss_was_on)
				begin
					compare_value("spi bit count", bit_count, SPI_W);
					compare_value("spi_mosi word", 32'(rx_word),
						32'(CMD_TABLE[xfer_idx].command));
					compare_value("spi_sclk high before release", cycle - last_rise,
						CLK_RATIO / 2);
					xfer_idx = xfer_idx + 1;
				end
			end
			ss_was_on = select_active(spi_ss);
			sclk_prev = spi_sclk;
		end
	end

	// pixel stream checker
	always @(negedge user_clock)
	begin
		if (rst_n && fifo_dout_valid)
		begin
			out_word = {out_word[17:0], dout};
			if (!ovf_mode)
			begin
				if (exp_words.size() == 0)
					abort_run("fifo_dout_valid with no pixel word outstanding");
				compare_value("dout", 32'(dout), 32'(slice_of(exp_words[0], slice_k)));
			end
			slice_k = slice_k + 1;
			if (slice_k == N_SLICES)
			begin
				slice_k = 0;
				if (ovf_mode)
					match_overflow_word(out_word);
				else
					void'(exp_words.pop_front());
			end
		end
	end

	// readout clock rise to rise
	always @(negedge user_clock)
	begin
		if (rst_n)
		begin
			if (adc_read_aclk && !aclk_prev)
			begin
				if (aclk_rises > 0)
					compare_value("adc_read_aclk period", cycle - aclk_rise, ACLK_RATIO);
				aclk_rises = aclk_rises + 1;
				aclk_rise  = cycle;
			end
			aclk_prev = adc_read_aclk;
		end
	end

////////////////////////////////////////
// stimulus

	initial
	begin
		int          t;
		logic [31:0] bits;
		logic [31:0] gap;
		ss_vec_t     ss_idle;
		adc_data1    = '0;
		adc_data2    = '0;
		adc_data3    = '0;
		sample_valid = 1'b0;
		ss_idle      = ~SS_ACTIVE_HIGH;       // every select at its idle level

		for (t = 0; rst_n !== 1'b1; t++)
		begin
			if (t == 100)
				abort_run("timeout waiting for reset release");
			@(posedge user_clock);
		end
		@(negedge user_clock);
		compare_value("spi_ss", 32'(spi_ss), 32'(ss_idle));
		compare_value("spi_sclk", 32'(spi_sclk), 32'(0));
		compare_value("spi_mosi", 32'(spi_mosi), 32'(0));
		compare_value("config_done", 32'(config_done), 32'(0));
		compare_value("fifo_dout_valid", 32'(fifo_dout_valid), 32'(0));
		compare_value("fifo_overflow", 32'(fifo_overflow), 32'(0));
		compare_value("adc_read_aclk", 32'(adc_read_aclk), 32'(0));

		for (t = 0; !config_done; t++)
		begin
			if (t == 6000)
				abort_run("timeout waiting for config_done");
			@(negedge user_clock);
		end
		compare_value("spi transfer count", xfer_idx, N_CMDS);

		// random samples spaced so the reader keeps up
		for (int n = 0; n < 40; n++)
		begin
			take_bits(24, bits);
			take_bits(4, gap);
			@(negedge user_clock);
			drive_sample(bits[23:0]);
			exp_words.push_back(bits[23:0]);
			@(negedge user_clock);
			sample_valid = 1'b0;
			repeat (16 + gap) @(negedge user_clock);
		end
		for (t = 0; exp_words.size() != 0; t++)
		begin
			if (t == 2000)
				abort_run("timeout waiting for the pixel words to come out");
			@(negedge user_clock);
		end

		// a sample every cycle for three depths
		ovf_mode = 1'b1;
		for (int n = 0; n < 3 * FIFO_DEPTH; n++)
		begin
			take_bits(24, bits);
			@(negedge user_clock);
			drive_sample(bits[23:0]);
			ovf_written.push_back(bits[23:0]);
		end
		@(negedge user_clock);
		sample_valid = 1'b0;
		t = 0;
		for (int idle = 0; idle < 8 * READ_RATIO; idle = fifo_dout_valid ? 0 : idle + 1)
		begin
			if (t == 4000)
				abort_run("timeout waiting for the FIFO to drain after overflow");
			t++;
			@(negedge user_clock);
		end
		compare_value("fifo_overflow", 32'(fifo_overflow), 32'(1));
		if (ovf_out < FIFO_DEPTH || slice_k != 0)
			abort_run("overflow read back ended short or inside a word");
		else if (aclk_rises < 2)
			abort_run("adc_read_aclk never completed a period");
		else
		begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

//--- compile.f
src/mb_pkg.sv
src/spi_cmd_if.sv
src/spi_master.sv
src/spi_programmer.sv
src/pixel_fifo.sv
src/aclk_generator.sv
src/mb_top.sv
bench/tb_clock.sv
bench/mb_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = mb_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
SOURCES   = $(wildcard src/*.sv bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
